// ==== Makefile ====
TOP = h80_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== dv/h80_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_mem_model (
   input  wire         clk,
   input  wire         reset,
   input  wire         cyc,
   input  wire         stb,
   input  wire         we,
   input  wire  [15:0] adr,
   input  wire  [15:0] dat_w,
   output logic [15:0] dat_r,
   output logic        ack,
   output logic        wr_seen,
   output logic [15:0] wr_addr,
   output logic [15:0] wr_data
);

   logic [15:0] mem [0:32767];  // one word per even byte address
   integer      seed = 32'h5473_363c;
   int          delay;
   int          wait_left;
   logic        armed;

   initial begin
      dat_r   = 16'h0000;
      ack     = 1'b0;
      wr_seen = 1'b0;
      armed   = 1'b0;
   end

   task respond;
      ack <= 1'b1;
      if (we) begin
         mem[adr[15:1]] <= dat_w;  // bit 0 ignored
         wr_seen        <= 1'b1;
         wr_addr        <= adr;
         wr_data        <= dat_w;
      end else begin
         dat_r <= mem[adr[15:1]];
      end
   endtask

   // core inputs change on the falling edge
   always @(negedge clk) begin
      ack     <= 1'b0;
      wr_seen <= 1'b0;
      if (reset) begin
         armed     <= 1'b0;
         wait_left <= 0;
      end else if (cyc && stb && !ack) begin
         if (armed && wait_left != 0) begin
            wait_left <= wait_left - 1;
         end else if (armed) begin
            respond();
            armed <= 1'b0;
         end else begin
            delay = $unsigned($random(seed)) % 3;  // 0 to 2 wait cycles
            if (delay == 0) begin
               respond();
            end else begin
               armed     <= 1'b1;
               wait_left <= delay - 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/h80_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_tb;

   import h80_pkg::*;

   localparam addr_t    start_addr = 16'h0100;
   localparam int       run_limit  = 20000;  // cycles until halted
   localparam reg_num_t r_zero     = 4'd0;   // never written
   localparam reg_num_t r_opa      = 4'd4;
   localparam reg_num_t r_opb      = 4'd5;
   localparam reg_num_t r_res      = 4'd6;
   localparam reg_num_t r_mark_nt  = 4'd7;   // marker for a jump not taken
   localparam reg_num_t r_mark_t   = 4'd8;
   localparam reg_num_t r_load     = 4'd9;
   localparam reg_num_t r_base     = 4'd13;  // holds 16'h0100
   localparam reg_num_t r_target   = 4'd14;
   localparam reg_num_t r_ptr      = 4'd15;

   logic  clk   = 1'b0;
   logic  reset = 1'b1;
   logic  wb_cyc, wb_stb, wb_we, wb_ack, halted, wr_seen;
   addr_t wb_adr, wr_addr;
   word_t wb_dat_w, wb_dat_r, wr_data, load_value;

   integer seed = 32'h5473_363c;
   int     errors = 0;
   int     checks = 0;
   int     cycles;
   int     read_count  = 0;
   int     write_count = 0;
   addr_t  asm_pc, out_ptr, opnd_ptr;
   string  exp_name_q[$];
   addr_t  exp_addr_q[$];
   word_t  exp_data_q[$];

   always #2 clk = ~clk;

   h80_core #(
      .reset_addr (start_addr)
   ) h80_core_inst (
      .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
      .wb_ack, .halted
   );

   h80_mem_model mem_model_inst (
      .clk, .reset, .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
      .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack), .wr_seen, .wr_addr, .wr_data
   );

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("[ERROR] %s expected %h actual %h", name, exp, act);
      end
   endtask

   // bus monitor sampling with the core on the rising edge
   always @(posedge clk) begin
      if (!reset) begin
         if (wb_cyc) begin
            check_word("wb_stb in cycle", 16'h0001, {15'd0, wb_stb});
         end else begin
            check_word("wb_stb idle", 16'h0000, {15'd0, wb_stb});
         end
      end
      if (!reset && wb_cyc && wb_ack && !wb_we) begin
         if (read_count < 8) begin
            check_word($sformatf("fetch %0d", read_count),
                       start_addr + 16'(2 * read_count), wb_adr);
         end
         read_count++;
      end
      if (wr_seen) begin
         if (write_count < exp_addr_q.size()) begin
            check_word($sformatf("%s addr", exp_name_q[write_count]),
                       exp_addr_q[write_count], wr_addr);
            check_word($sformatf("%s data", exp_name_q[write_count]),
                       exp_data_q[write_count], wr_data);
         end else begin
            errors++;
            $display("unexpected write of %h at address %h", wr_data, wr_addr);
         end
         write_count++;
      end
   end

   function automatic instr_t enc_rrr(input opcode_t op, input reg_num_t d, a, b);
      return {op, d, a, b};
   endfunction

   function automatic instr_t enc_imm(input opcode_t op, input reg_num_t d, input logic [7:0] v);
      return {op, d, v};
   endfunction

   function automatic instr_t enc_bus(input logic store, input reg_num_t a, b);
      return {op_bus, store ? bus_write_w : bus_read_w, 1'b0, a, b};
   endfunction

   // zero, carry and sign from the 17-bit sum and overflow from the signed range
   function automatic flags_t expected_flags(input logic is_add, input word_t a, b);
      logic [16:0] sum;
      int          s;
      flags_t      f;
      sum  = is_add ? {1'b0, a} + {1'b0, b} : {1'b0, a} - {1'b0, b};
      s    = is_add ? int'($signed(a)) + int'($signed(b)) : int'($signed(a)) - int'($signed(b));
      f[0] = (sum[15:0] == 16'h0000);
      f[1] = sum[16];
      f[2] = sum[15];
      f[3] = (s > 32767) || (s < -32768);
      return f;
   endfunction

   task automatic emit(input instr_t ins);
      mem_model_inst.mem[asm_pc[15:1]] = ins;
      asm_pc = asm_pc + 16'd2;
   endtask

   task automatic expect_write(input string name, input addr_t addr, input word_t data);
      exp_name_q.push_back(name);
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(data);
   endtask

   task automatic store_result(input string name, input reg_num_t r, input word_t exp);
      emit(enc_imm(op_imm_zext, r_ptr, out_ptr[7:0]));
      emit(enc_bus(1'b1, r, r_ptr));
      expect_write(name, out_ptr, exp);
      out_ptr = out_ptr + 16'd2;
   endtask

   task automatic load_word(input reg_num_t r, input word_t value);
      mem_model_inst.mem[opnd_ptr[15:1]] = value;  // operand area
      emit(enc_imm(op_imm_zext, r_ptr, opnd_ptr[7:0]));
      emit(enc_bus(1'b0, r, r_ptr));
      opnd_ptr = opnd_ptr + 16'd2;
   endtask

   // low byte first and then the high byte as up to three adds of r_base
   task automatic load_target(input addr_t target);
      int hi;
      hi = int'(target[15:8]);
      emit(enc_imm(op_imm_zext, r_target, target[7:0]));
      for (int i = 0; i < 3; i++) begin
         emit(enc_rrr(op_add, r_target, r_target, (i < hi) ? r_base : r_zero));
      end
   endtask

   task automatic jump_block(input string name, input instr_t flag_op, input instr_t jump_ins,
                             input logic taken);
      load_target(asm_pc + 16'd16);  // lands on the second store
      emit(enc_imm(op_imm_zext, r_ptr, out_ptr[7:0]));
      emit(flag_op);
      emit(jump_ins);
      emit(enc_bus(1'b1, r_mark_nt, r_ptr));
      emit(enc_bus(1'b1, r_mark_t, r_ptr));
      if (!taken) begin
         expect_write(name, out_ptr, 16'h00aa);
      end
      expect_write(name, out_ptr, 16'h0055);
      out_ptr = out_ptr + 16'd2;
   endtask

   task automatic flag_pair(input logic is_add, input word_t a, input word_t b);
      flags_t fl;
      instr_t op;
      load_word(r_opa, a);
      load_word(r_opb, b);
      fl = expected_flags(is_add, a, b);
      op = is_add ? enc_rrr(op_add, r_res, r_opa, r_opb) : enc_rrr(op_cp, r_zero, r_opa, r_opb);
      for (int f = 0; f < 4; f++) begin
         for (int c = 0; c < 2; c++) begin
            jump_block($sformatf("%s %h %h flag %0d c %0d", is_add ? "add" : "cp", a, b, f, c),
                       op, {8'h03, 1'b0, c[0], f[1:0], r_target}, fl[f] == c[0]);
         end
      end
   endtask

   task automatic alu_set();
      word_t a, b;
      a = word_t'($random(seed));
      b = word_t'($random(seed));
      load_word(r_opa, a);
      load_word(r_opb, b);
      emit(enc_rrr(op_add, r_res, r_opa, r_opb));
      store_result($sformatf("add %h %h", a, b), r_res, a + b);
      emit(enc_rrr(op_sub, r_res, r_opa, r_opb));
      store_result($sformatf("sub %h %h", a, b), r_res, a - b);
      emit(enc_rrr(op_and, r_res, r_opa, r_opb));
      store_result($sformatf("and %h %h", a, b), r_res, a & b);
      emit(enc_rrr(op_or, r_res, r_opa, r_opb));
      store_result($sformatf("or %h %h", a, b), r_res, a | b);
      emit(enc_rrr(op_xor, r_res, r_opa, r_opb));
      store_result($sformatf("xor %h %h", a, b), r_res, a ^ b);
   endtask

   task automatic build_program();
      asm_pc   = start_addr;
      out_ptr  = 16'h0010;  // results
      opnd_ptr = 16'h00c0;  // preloaded operands
      emit(enc_imm(op_imm_zext, r_base, 8'h80));
      emit(enc_rrr(op_add, r_base, r_base, r_base));
      emit(enc_imm(op_imm_zext, r_mark_nt, 8'haa));
      emit(enc_imm(op_imm_zext, r_mark_t, 8'h55));
      emit(enc_imm(op_imm_zext, 4'd1, 8'h9c));
      emit(enc_imm(op_imm_sext, 4'd2, 8'h9c));
      emit(enc_imm(op_imm_sext, 4'd3, 8'h35));
      store_result("imm zext 9c", 4'd1, 16'h009c);
      store_result("imm sext 9c", 4'd2, 16'hff9c);
      store_result("imm sext 35", 4'd3, 16'h0035);
      flag_pair(1'b0, 16'h1234, 16'h1234);
      flag_pair(1'b0, 16'h0001, 16'h0002);
      flag_pair(1'b1, 16'h7fff, 16'h0001);
      flag_pair(1'b1, 16'hffff, 16'h0001);
      jump_block("jp r", 16'h0000, {8'h01, 4'he, r_target}, 1'b1);
      repeat (3) alu_set();
      load_value = word_t'($random(seed));
      load_word(r_load, load_value);
      store_result("word load", r_load, load_value);
      emit(16'h0001);  // halt
   endtask

   task automatic check_bus_counts();
      if (read_count < 8) begin
         errors++;
         $display("only %0d bus reads seen before halt", read_count);
      end
      if (write_count != exp_addr_q.size()) begin
         errors++;
         $display("[ERROR] write count expected %0d actual %0d",
                  exp_addr_q.size(), write_count);
      end
   endtask

   initial begin
      build_program();
      repeat (3) begin
         @(negedge clk);
         check_word("reset wb_cyc", 16'h0000, {15'd0, wb_cyc});
         check_word("reset wb_stb", 16'h0000, {15'd0, wb_stb});
         check_word("reset halted", 16'h0000, {15'd0, halted});
      end
      reset  = 1'b0;
      cycles = 0;
      while (!halted && cycles < run_limit) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         errors++;
         $display("timeout, core did not halt within %0d cycles", run_limit);
      end else begin
         for (int i = 0; i < 50; i++) begin  // bus stays idle after halt
            @(negedge clk);
            check_word("halt wb_cyc", 16'h0000, {15'd0, wb_cyc});
            check_word("halt halted", 16'h0001, {15'd0, halted});
         end
         check_bus_counts();
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/h80_pkg.sv
verilog/h80_regfile.sv
verilog/h80_alu.sv
verilog/h80_decode.sv
verilog/h80_sequencer.sv
verilog/h80_core.sv
dv/h80_mem_model.sv
dv/h80_tb.sv

// ==== verilog/h80_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_alu (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    exec_en,
   input  wire                    flag_we,
   input  wire h80_pkg::alu_op_t  alu_op,
   input  wire h80_pkg::word_t    ra_data,
   input  wire h80_pkg::word_t    rb_data,
   input  wire h80_pkg::word_t    imm,
   input  wire                    use_imm,
   output h80_pkg::word_t         result,
   output h80_pkg::flags_t        flags
);

   import h80_pkg::*;

   localparam int sb = $bits(word_t) - 1;  // sign bit

   word_t              b_op;
   logic [$bits(word_t):0] a_ext, b_ext, res;  // extra bit is the carry
   logic               ov_add, ov_sub;
   flags_t             next_flags;

   assign b_op  = use_imm ? imm : rb_data;
   assign a_ext = {1'b0, ra_data};
   assign b_ext = {1'b0, b_op};

   always_comb begin
      case (alu_op)
         alu_add:         res = a_ext + b_ext;
         alu_sub, alu_cp: res = a_ext - b_ext;  // borrow in the top bit
         alu_and:         res = a_ext & b_ext;
         alu_or:          res = a_ext | b_ext;
         alu_xor:         res = a_ext ^ b_ext;
         default:         res = b_ext;
      endcase
   end

   assign result = res[sb:0];

   assign ov_add = (a_ext[sb] == b_ext[sb]) && (a_ext[sb] != res[sb]);
   assign ov_sub = (a_ext[sb] != b_ext[sb]) && (a_ext[sb] != res[sb]);

   always_comb begin
      next_flags             = flags;
      next_flags[flag_sign]  = res[sb];
      next_flags[flag_zero]  = (res[sb:0] == '0);
      if (alu_op == alu_add || alu_op == alu_sub || alu_op == alu_cp) begin
         next_flags[flag_carry]    = res[sb+1];
         next_flags[flag_overflow] = (alu_op == alu_add) ? ov_add : ov_sub;
      end else begin
         next_flags[flag_carry]    = 1'b0;
         next_flags[flag_overflow] = ~^res[sb:0];  // even parity
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;
      end else if (exec_en && flag_we) begin
         flags <= next_flags;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/h80_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_core #(
   parameter h80_pkg::addr_t reset_addr = '0
) (
   input  wire             clk,
   input  wire             reset,
   output wire             wb_cyc,
   output wire             wb_stb,
   output wire             wb_we,
   output h80_pkg::addr_t  wb_adr,
   output h80_pkg::word_t  wb_dat_w,
   input  wire h80_pkg::word_t wb_dat_r,
   input  wire             wb_ack,
   output wire             halted
);

   import h80_pkg::*;

   instr_t    ins;
   reg_num_t  ra, rb, rd;
   word_t     imm;
   logic      use_imm;
   alu_op_t   alu_op;
   logic      reg_we, flag_we, mem_rd, mem_wr;
   logic      jump, jump_cond, cond_true, halt;
   flag_num_t cond_flag;
   word_t     ra_data, rb_data;
   word_t     result;
   flags_t    flags;
   logic      exec_en;
   logic      wr_en;
   reg_num_t  wr_num;
   word_t     wr_data;

   h80_sequencer #(
      .reset_addr (reset_addr)
   ) h80_sequencer_inst (
      .clk, .reset, .wb_dat_r, .wb_ack, .ra_data, .rb_data, .result, .flags,
      .reg_we, .mem_rd, .mem_wr, .jump, .jump_cond, .cond_flag, .cond_true,
      .halt, .ra, .rd, .ins, .exec_en, .wr_en, .wr_num, .wr_data,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .halted
   );

   h80_decode h80_decode_inst (
      .ins, .ra, .rb, .rd, .imm, .use_imm, .alu_op, .reg_we, .flag_we,
      .mem_rd, .mem_wr, .jump, .jump_cond, .cond_flag, .cond_true, .halt
   );

   h80_alu h80_alu_inst (
      .clk, .reset, .exec_en, .flag_we, .alu_op, .ra_data, .rb_data,
      .imm, .use_imm, .result, .flags
   );

   h80_regfile h80_regfile_inst (
      .clk, .reset, .ra, .rb, .wr_en, .wr_num, .wr_data, .ra_data, .rb_data
   );

endmodule

`default_nettype wire

// ==== verilog/h80_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_decode (
   input  wire h80_pkg::instr_t    ins,
   output h80_pkg::reg_num_t       ra,
   output h80_pkg::reg_num_t       rb,
   output h80_pkg::reg_num_t       rd,
   output h80_pkg::word_t          imm,
   output logic                    use_imm,
   output h80_pkg::alu_op_t        alu_op,
   output logic                    reg_we,
   output logic                    flag_we,
   output logic                    mem_rd,
   output logic                    mem_wr,
   output logic                    jump,
   output logic                    jump_cond,
   output h80_pkg::flag_num_t      cond_flag,
   output logic                    cond_true,
   output logic                    halt
);

   import h80_pkg::*;

   // fixed field positions across the whole map
   assign rd = ins[11:8];
   assign ra = ins[7:4];
   assign rb = ins[3:0];

   assign imm = (ins[15:12] == op_imm_sext) ? {{8{ins[7]}}, ins[7:0]}
                                            : {8'h00, ins[7:0]};

   assign cond_flag = ins[5:4];  // ff
   assign cond_true = ins[6];    // c, JP when set and JPN when clear

   always_comb begin
      use_imm   = 1'b0;
      alu_op    = alu_pass;
      reg_we    = 1'b0;
      flag_we   = 1'b0;
      mem_rd    = 1'b0;
      mem_wr    = 1'b0;
      jump      = 1'b0;
      jump_cond = 1'b0;
      halt      = 1'b0;

      case (ins[15:12])
         op_add: begin
            alu_op  = alu_add;
            reg_we  = 1'b1;
            flag_we = 1'b1;
         end
         op_sub: begin
            alu_op  = alu_sub;
            reg_we  = 1'b1;
            flag_we = 1'b1;
         end
         op_and: begin
            alu_op  = alu_and;
            reg_we  = 1'b1;
            flag_we = 1'b1;
         end
         op_or: begin
            alu_op  = alu_or;
            reg_we  = 1'b1;
            flag_we = 1'b1;
         end
         op_xor: begin
            alu_op  = alu_xor;
            reg_we  = 1'b1;
            flag_we = 1'b1;
         end
         op_cp: begin
            alu_op  = alu_cp;  // flags only
            flag_we = 1'b1;
         end
         op_imm_zext, op_imm_sext: begin
            use_imm = 1'b1;
            reg_we  = 1'b1;
         end
         op_bus: begin
            if (!ins[8]) begin  // memory bus only
               mem_rd = (ins[11:9] == bus_read_w);
               mem_wr = (ins[11:9] == bus_write_w);
            end
         end
         op_misc: begin
            if (ins == ins_halt) begin
               halt = 1'b1;
            end else if (ins[11:4] == jp_reg_code) begin
               jump = 1'b1;
            end else if (ins[11:7] == jp_cond_code) begin
               jump      = 1'b1;
               jump_cond = 1'b1;
            end
         end
         default: begin
            // mul, div and unused codes act as nop
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/h80_pkg.sv ====
`default_nettype none

package h80_pkg;

   typedef logic [15:0] word_t;      // register and bus data
   typedef logic [15:0] addr_t;      // byte address
   typedef logic [15:0] instr_t;     // one instruction word
   typedef logic [3:0]  reg_num_t;   // general register number
   typedef logic [1:0]  flag_num_t;  // index into the flag register
   typedef logic [3:0]  flags_t;     // zero, carry, sign, overflow
   typedef logic [3:0]  opcode_t;    // top nibble of an instruction
   typedef logic [2:0]  bus_cmd_t;   // ttt field of a bus instruction
   typedef logic [2:0]  alu_op_t;

   localparam flag_num_t flag_zero     = 2'd0;
   localparam flag_num_t flag_carry    = 2'd1;
   localparam flag_num_t flag_sign     = 2'd2;
   localparam flag_num_t flag_overflow = 2'd3;

   localparam alu_op_t alu_add  = 3'd0;
   localparam alu_op_t alu_sub  = 3'd1;
   localparam alu_op_t alu_and  = 3'd2;
   localparam alu_op_t alu_or   = 3'd3;
   localparam alu_op_t alu_xor  = 3'd4;
   localparam alu_op_t alu_cp   = 3'd5;
   localparam alu_op_t alu_pass = 3'd6;  // forwards the immediate

   // top nibble of the instruction word
   localparam opcode_t op_misc     = 4'h0;  // nop, halt, jumps
   localparam opcode_t op_imm_zext = 4'h1;  // dddd nnnnnnnn, zero extended
   localparam opcode_t op_imm_sext = 4'h2;  // dddd nnnnnnnn, sign extended
   localparam opcode_t op_bus      = 4'h3;  // tttn aaaa bbbb
   localparam opcode_t op_add      = 4'h8;
   localparam opcode_t op_sub      = 4'h9;
   localparam opcode_t op_and      = 4'hc;
   localparam opcode_t op_or       = 4'hd;
   localparam opcode_t op_xor      = 4'he;
   localparam opcode_t op_cp       = 4'hf;

   localparam instr_t ins_halt = 16'h0001;

   localparam logic [7:0] jp_reg_code  = 8'b0001_1110;  // ins[11:4] of JP R
   localparam logic [4:0] jp_cond_code = 5'b0011_0;     // ins[11:7] of JP/JPN f,(R)

   localparam bus_cmd_t bus_read_w  = 3'b010;
   localparam bus_cmd_t bus_write_w = 3'b011;

   localparam addr_t instr_step = 16'd2;  // one instruction word

   typedef enum logic [1:0] {
      s_fetch,
      s_execute,
      s_mem,
      s_halt
   } seq_state_t;

endpackage

`default_nettype wire

// ==== verilog/h80_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_regfile (
   input  wire                     clk,
   input  wire                     reset,
   input  wire h80_pkg::reg_num_t  ra,
   input  wire h80_pkg::reg_num_t  rb,
   input  wire                     wr_en,
   input  wire h80_pkg::reg_num_t  wr_num,
   input  wire h80_pkg::word_t     wr_data,
   output h80_pkg::word_t          ra_data,
   output h80_pkg::word_t          rb_data
);

   import h80_pkg::*;

   localparam int num_regs = 2 ** $bits(reg_num_t);

   word_t regs [num_regs];

   // two asynchronous read ports
   assign ra_data = regs[ra];
   assign rb_data = regs[rb];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_num] <= wr_data;  // alu result or load data
      end
   end

endmodule

`default_nettype wire

// ==== verilog/h80_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_sequencer #(
   parameter h80_pkg::addr_t reset_addr = '0
) (
   input  wire                   clk,
   input  wire                   reset,
   input  wire h80_pkg::word_t   wb_dat_r,
   input  wire                   wb_ack,
   input  wire h80_pkg::word_t   ra_data,
   input  wire h80_pkg::word_t   rb_data,
   input  wire h80_pkg::word_t   result,
   input  wire h80_pkg::flags_t  flags,
   input  wire                   reg_we,
   input  wire                   mem_rd,
   input  wire                   mem_wr,
   input  wire                   jump,
   input  wire                   jump_cond,
   input  wire h80_pkg::flag_num_t cond_flag,
   input  wire                   cond_true,
   input  wire                   halt,
   input  wire h80_pkg::reg_num_t ra,
   input  wire h80_pkg::reg_num_t rd,
   output h80_pkg::instr_t       ins,
   output logic                  exec_en,
   output logic                  wr_en,
   output h80_pkg::reg_num_t     wr_num,
   output h80_pkg::word_t        wr_data,
   output logic                  wb_cyc,
   output logic                  wb_stb,
   output logic                  wb_we,
   output h80_pkg::addr_t        wb_adr,
   output h80_pkg::word_t        wb_dat_w,
   output logic                  halted
);

   import h80_pkg::*;

   seq_state_t state;
   addr_t      pc;
   logic       taken;
   logic       mem_op;

   assign mem_op = mem_rd | mem_wr;
   assign taken  = jump & (~jump_cond | (flags[cond_flag] == cond_true));

   assign exec_en = (state == s_execute);
   assign halted  = (state == s_halt);

   // load data lands in ra at the end of the bus cycle
   assign wr_en   = (exec_en & reg_we) | ((state == s_mem) & mem_rd & wb_ack);
   assign wr_num  = (state == s_mem) ? ra : rd;
   assign wr_data = (state == s_mem) ? wb_dat_r : result;

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= s_fetch;
         pc     <= reset_addr;
         wb_cyc <= 1'b0;
         wb_stb <= 1'b0;
         wb_we  <= 1'b0;
      end else begin
         case (state)
            s_fetch: begin
               if (!wb_cyc) begin
                  wb_cyc <= 1'b1;  // instruction read
                  wb_stb <= 1'b1;
                  wb_we  <= 1'b0;
               end else if (wb_ack) begin
                  wb_cyc <= 1'b0;
                  wb_stb <= 1'b0;
                  state  <= s_execute;
               end
            end
            s_execute: begin
               pc <= taken ? addr_t'(rb_data) : pc + instr_step;
               if (halt) begin
                  state <= s_halt;
               end else if (mem_op) begin
                  wb_cyc <= 1'b1;  // data cycle starts at once
                  wb_stb <= 1'b1;
                  wb_we  <= mem_wr;
                  state  <= s_mem;
               end else begin
                  state <= s_fetch;
               end
            end
            s_mem: begin
               if (wb_ack) begin
                  wb_cyc <= 1'b0;
                  wb_stb <= 1'b0;
                  wb_we  <= 1'b0;
                  state  <= s_fetch;
               end
            end
            default: begin
               // s_halt, left only by reset
            end
         endcase
      end
   end

   // instruction register and bus payload
   always_ff @(posedge clk) begin
      if (state == s_fetch && !wb_cyc) begin
         wb_adr <= pc;
      end
      if (state == s_fetch && wb_cyc && wb_ack) begin
         ins <= wb_dat_r;  // sampled in the ack cycle
      end
      if (state == s_execute && mem_op && !halt) begin
         wb_adr   <= addr_t'(rb_data);  // register-held address
         wb_dat_w <= ra_data;
      end
   end

endmodule

`default_nettype wire
